// ==== src/ntm_consts.svh ====
// Vector engine constants
`ifndef NTM_CONSTS_SVH
`define NTM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Operand, modulus and result width
`define NTM_DATA_SIZE 16

// Width of the vector length field
`define NTM_LENGTH_SIZE 8

//////////////////////////////////////////////////////////////////////
// Timing
//////////////////////////////////////////////////////////////////////

// Scalar start to scalar ready, one cycle per operand bit plus one
`define NTM_SCALAR_LATENCY (`NTM_DATA_SIZE + 1)

`endif

// ==== src/ntm_pkg.sv ====
// Vector engine types
`include "ntm_consts.svh"

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Config register map
  //////////////////////////////////////////////////////////////////////

  // One address bit selects the register
  typedef enum logic {
    CFG_MODULO = 1'b0,
    CFG_LENGTH = 1'b1
  } ntm_cfg_reg_e;

  // Configuration as seen by the controller
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0]   modulo;
    logic [`NTM_LENGTH_SIZE-1:0] length;
    // Modulus above 1 and length nonzero
    logic                        valid;
  } ntm_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////////////////////////

  // Vector controller
  typedef enum logic [1:0] {
    STARTER = 2'd0,
    INPUT   = 2'd1,
    ENDER   = 2'd2
  } ntm_vector_state_e;

  // Scalar multiplier
  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } ntm_scalar_state_e;

endpackage

// ==== src/ntm_vector_config.sv ====
// Vector engine config registers
`include "ntm_consts.svh"

module ntm_vector_config
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,

  // Write port
  input  logic                      cfg_write,
  input  ntm_cfg_reg_e              cfg_addr,
  input  logic [`NTM_DATA_SIZE-1:0] cfg_wdata,

  // From the controller
  input  logic                      busy,

  // To the controller
  output ntm_cfg_t                  cfg
);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  logic [`NTM_DATA_SIZE-1:0]   modulo_reg;
  logic [`NTM_LENGTH_SIZE-1:0] length_reg;

  // Write is dropped while a run is in progress
  logic                        write_ok;

  assign write_ok = cfg_write && !busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo_reg <= '0;
      length_reg <= '0;
    end else if (write_ok) begin
      // Address decode
      case (cfg_addr)
        CFG_MODULO: modulo_reg <= cfg_wdata;
        // Length takes the low bits of the word
        CFG_LENGTH: length_reg <= cfg_wdata[`NTM_LENGTH_SIZE-1:0];
        default:    modulo_reg <= modulo_reg;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cfg.modulo = modulo_reg;
    cfg.length = length_reg;
    // Modulus 0 or 1 gives no useful product
    cfg.valid  = (modulo_reg > `NTM_DATA_SIZE'(1)) && (length_reg != '0);
  end

endmodule

// ==== src/ntm_scalar_multiplier.sv ====
// Iterative modular scalar multiplier
`include "ntm_consts.svh"

module ntm_scalar_multiplier
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,

  // Control
  input  logic                      scalar_start,
  output logic                      scalar_ready,

  // Operands, held stable by the caller during a run
  input  logic [`NTM_DATA_SIZE-1:0] modulo,
  input  logic [`NTM_DATA_SIZE-1:0] data_a,
  input  logic [`NTM_DATA_SIZE-1:0] data_b,
  output logic [`NTM_DATA_SIZE-1:0] product
);

  //////////////////////////////////////////////////////////////////////
  // Local widths
  //////////////////////////////////////////////////////////////////////

  // Counter runs from the data width down to zero
  localparam int CNT_W = $clog2(`NTM_SCALAR_LATENCY);
  localparam int IDX_W = $clog2(`NTM_DATA_SIZE);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_state_e           state;
  logic [CNT_W-1:0]            bit_count;
  logic [IDX_W-1:0]            bit_idx;

  // Partial result, always below the modulus
  logic [`NTM_DATA_SIZE-1:0]   acc;
  logic [`NTM_DATA_SIZE-1:0]   acc_next;

  // One guard bit for the intermediate sums
  logic [`NTM_DATA_SIZE:0]     mod_ext;
  logic [`NTM_DATA_SIZE:0]     dbl;
  logic [`NTM_DATA_SIZE:0]     dbl_red;
  logic [`NTM_DATA_SIZE:0]     sum;
  logic [`NTM_DATA_SIZE:0]     sum_red;

  logic                        load;
  logic                        step;

  assign load    = (state == IDLE) && scalar_start;
  assign step    = (state == RUN) && (bit_count != '0);
  assign bit_idx = IDX_W'(bit_count - 1'b1);
  assign product = acc;

  //////////////////////////////////////////////////////////////////////
  // Shift and add step
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mod_ext  = {1'b0, modulo};
    // Double, then bring back below the modulus
    dbl      = {acc, 1'b0};
    dbl_red  = (dbl >= mod_ext) ? (dbl - mod_ext) : dbl;
    // Add A when the current B bit is set
    sum      = dbl_red + (data_b[bit_idx] ? {1'b0, data_a} : '0);
    sum_red  = (sum >= mod_ext) ? (sum - mod_ext) : sum;
    acc_next = sum_red[`NTM_DATA_SIZE-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE;
      bit_count    <= '0;
      scalar_ready <= 1'b0;
    end else begin
      scalar_ready <= 1'b0;
      case (state)
        IDLE: begin
          if (scalar_start) begin
            // MSB of B first
            bit_count <= CNT_W'(`NTM_DATA_SIZE);
            state     <= RUN;
          end
        end
        RUN: begin
          if (bit_count != '0) begin
            bit_count <= bit_count - 1'b1;
          end else begin
            // All bits consumed, product is final
            scalar_ready <= 1'b1;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Partial result
  always_ff @(posedge CLK) begin
    if (load) begin
      acc <= '0;
    end else if (step) begin
      acc <= acc_next;
    end
  end

endmodule

// ==== src/ntm_vector_multiplier.sv ====
// Element-wise modular vector multiplier
`include "ntm_consts.svh"

module ntm_vector_multiplier
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,

  // Control
  input  logic                      start,
  output logic                      ready,

  // Configuration
  input  ntm_cfg_t                  cfg,
  output logic                      busy,

  // Operand strobes
  input  logic                      data_a_in_enable,
  input  logic                      data_b_in_enable,

  // Data
  input  logic [`NTM_DATA_SIZE-1:0] data_a_in,
  input  logic [`NTM_DATA_SIZE-1:0] data_b_in,
  output logic [`NTM_DATA_SIZE-1:0] data_out,
  output logic                      data_out_enable
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_vector_state_e           state;

  // Element counting
  logic [`NTM_LENGTH_SIZE-1:0] index_loop;
  logic [`NTM_LENGTH_SIZE-1:0] last_index;

  // Operand captured flags
  logic                        a_flag;
  logic                        b_flag;
  logic                        pair_done;
  logic                        accept;

  // Scalar unit
  logic                        scalar_start;
  logic                        scalar_ready;
  logic [`NTM_DATA_SIZE-1:0]   modulo;
  logic [`NTM_DATA_SIZE-1:0]   data_a;
  logic [`NTM_DATA_SIZE-1:0]   data_b;
  logic [`NTM_DATA_SIZE-1:0]   product;

  assign busy   = (state != STARTER);
  assign accept = (state == STARTER) && start && cfg.valid;

  // Both operands present once this edge has captured them
  assign pair_done = (a_flag || data_a_in_enable) && (b_flag || data_b_in_enable);

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      index_loop      <= '0;
      last_index      <= '0;
      a_flag          <= 1'b0;
      b_flag          <= 1'b0;
      scalar_start    <= 1'b0;
      ready           <= 1'b0;
      data_out        <= '0;
      data_out_enable <= 1'b0;
    end else begin
      // Pulses by default
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      scalar_start    <= 1'b0;
      case (state)
        STARTER: begin
          // Invalid config ignores the start
          if (accept) begin
            index_loop <= '0;
            last_index <= cfg.length - 1'b1;
            a_flag     <= 1'b0;
            b_flag     <= 1'b0;
            state      <= INPUT;
          end
        end
        INPUT: begin
          if (pair_done) begin
            a_flag       <= 1'b0;
            b_flag       <= 1'b0;
            scalar_start <= 1'b1;
            state        <= ENDER;
          end else begin
            if (data_a_in_enable) a_flag <= 1'b1;
            if (data_b_in_enable) b_flag <= 1'b1;
          end
        end
        ENDER: begin
          // Forward the product with its strobe
          if (scalar_ready) begin
            data_out        <= product;
            data_out_enable <= 1'b1;
            if (index_loop == last_index) begin
              ready <= 1'b1;
              state <= STARTER;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= INPUT;
            end
          end
        end
        default: state <= STARTER;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand and modulus capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Modulus fixed for the whole run
    if (accept) modulo <= cfg.modulo;
    // Latest strobe wins
    if ((state == INPUT) && data_a_in_enable) data_a <= data_a_in;
    if ((state == INPUT) && data_b_in_enable) data_b <= data_b_in;
  end

  // One element in flight
  ntm_scalar_multiplier scalar_multiplier (
    .CLK          (CLK),
    .RST          (RST),
    .scalar_start (scalar_start),
    .scalar_ready (scalar_ready),
    .modulo       (modulo),
    .data_a       (data_a),
    .data_b       (data_b),
    .product      (product)
  );

endmodule

// ==== src/ntm_vector_top.sv ====
// Modular vector engine top level
`include "ntm_consts.svh"

module ntm_vector_top
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,

  // Config write port
  input  logic                      cfg_write,
  input  ntm_cfg_reg_e              cfg_addr,
  input  logic [`NTM_DATA_SIZE-1:0] cfg_wdata,

  // Vector control
  input  logic                      start,
  output logic                      ready,

  // Operands
  input  logic [`NTM_DATA_SIZE-1:0] data_a_in,
  input  logic                      data_a_in_enable,
  input  logic [`NTM_DATA_SIZE-1:0] data_b_in,
  input  logic                      data_b_in_enable,

  // Results
  output logic [`NTM_DATA_SIZE-1:0] data_out,
  output logic                      data_out_enable
);

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////

  ntm_cfg_t cfg;
  // Locks the config registers during a run
  logic     busy;

  ntm_vector_config vector_config (
    .CLK       (CLK),
    .RST       (RST),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .cfg       (cfg)
  );

  ntm_vector_multiplier vector_multiplier (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .ready            (ready),
    .cfg              (cfg),
    .busy             (busy),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in_enable (data_b_in_enable),
    .data_a_in        (data_a_in),
    .data_b_in        (data_b_in),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable)
  );

endmodule

// ==== test/ntm_clock_gen.sv ====
// Testbench clock and reset
module ntm_clock_gen (
  output logic CLK,
  output logic RST
);
  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Reset held for 8 rising edges, released just after the edge
  initial begin
    RST = 1'b1;
    repeat (8) @(posedge CLK);
    #2 RST = 1'b0;
  end

endmodule

// ==== test/ntm_vector_properties.sv ====
// Vector engine bound checks
`include "ntm_consts.svh"

module ntm_vector_properties
  import ntm_pkg::*;
(
  input logic                      CLK,
  input logic                      RST,
  input logic                      cfg_write,
  input ntm_cfg_reg_e              cfg_addr,
  input logic [`NTM_DATA_SIZE-1:0] cfg_wdata,
  input logic                      start,
  input logic                      ready,
  input logic [`NTM_DATA_SIZE-1:0] data_a_in,
  input logic                      data_a_in_enable,
  input logic [`NTM_DATA_SIZE-1:0] data_b_in,
  input logic                      data_b_in_enable,
  input logic [`NTM_DATA_SIZE-1:0] data_out,
  input logic                      data_out_enable,
  // Config as the controller sees it
  input ntm_cfg_t                  dut_cfg
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed checks so far, polled by the testbench top
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  ntm_vector_state_e           phase;
  logic [`NTM_DATA_SIZE-1:0]   mod_m;
  logic [`NTM_LENGTH_SIZE-1:0] len_m;
  // Snapshot taken at the accepted start
  logic [`NTM_DATA_SIZE-1:0]   mod_run;
  logic [`NTM_LENGTH_SIZE-1:0] len_run;
  logic [`NTM_DATA_SIZE-1:0]   cap_a;
  logic [`NTM_DATA_SIZE-1:0]   cap_b;
  logic [`NTM_DATA_SIZE-1:0]   op_a;
  logic [`NTM_DATA_SIZE-1:0]   op_b;
  logic [`NTM_DATA_SIZE-1:0]   exp_prod;
  logic                        a_seen;
  logic                        b_seen;
  logic                        pair_now;
  logic                        cfg_ok;
  // Expected strobes, one cycle wide like the DUT outputs
  logic                        exp_due;
  logic                        exp_last;
  int                          wait_cnt;
  int                          elem;

  // A times B reduced by the modulus, straight from the definition
  function automatic logic [`NTM_DATA_SIZE-1:0] expected_product(
    input logic [`NTM_DATA_SIZE-1:0] a,
    input logic [`NTM_DATA_SIZE-1:0] b,
    input logic [`NTM_DATA_SIZE-1:0] m
  );
    logic [31:0] full;
    full = (32'(a) * 32'(b)) % 32'(m);
    return full[`NTM_DATA_SIZE-1:0];
  endfunction

  assign cfg_ok   = (mod_m > `NTM_DATA_SIZE'(1)) && (len_m != '0);
  assign op_a     = data_a_in_enable ? data_a_in : cap_a;
  assign op_b     = data_b_in_enable ? data_b_in : cap_b;
  assign pair_now = (a_seen || data_a_in_enable) && (b_seen || data_b_in_enable);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= STARTER;
      mod_m    <= '0;
      len_m    <= '0;
      mod_run  <= '0;
      len_run  <= '0;
      cap_a    <= '0;
      cap_b    <= '0;
      exp_prod <= '0;
      a_seen   <= 1'b0;
      b_seen   <= 1'b0;
      exp_due  <= 1'b0;
      exp_last <= 1'b0;
      wait_cnt <= 0;
      elem     <= 0;
    end else begin
      exp_due  <= 1'b0;
      exp_last <= 1'b0;
      // Writes only land while idle
      if (cfg_write && (phase == STARTER)) begin
        if (cfg_addr == CFG_MODULO) mod_m <= cfg_wdata;
        else len_m <= cfg_wdata[`NTM_LENGTH_SIZE-1:0];
      end
      case (phase)
        STARTER: begin
          if (start && cfg_ok) begin
            mod_run <= mod_m;
            len_run <= len_m;
            elem    <= 0;
            a_seen  <= 1'b0;
            b_seen  <= 1'b0;
            phase   <= INPUT;
          end
        end
        INPUT: begin
          if (pair_now) begin
            exp_prod <= expected_product(op_a, op_b, mod_run);
            a_seen   <= 1'b0;
            b_seen   <= 1'b0;
            // Strobe rises latency plus 2 edges after the later strobe
            wait_cnt <= `NTM_SCALAR_LATENCY + 1;
            phase    <= ENDER;
          end else begin
            if (data_a_in_enable) a_seen <= 1'b1;
            if (data_a_in_enable) cap_a <= data_a_in;
            if (data_b_in_enable) b_seen <= 1'b1;
            if (data_b_in_enable) cap_b <= data_b_in;
          end
        end
        default: begin
          if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
          end else begin
            // Result strobe and next phase on the same edge
            exp_due <= 1'b1;
            if (elem == int'(len_run) - 1) begin
              exp_last <= 1'b1;
              phase    <= STARTER;
            end else begin
              elem  <= elem + 1;
              phase <= INPUT;
            end
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Strobe exactly when due, none outside a run
  result_timing: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable == exp_due)
    else begin
      fail_count++;
      $error("data_out_enable at %0t does not match the expected timing", $time);
    end

  result_value: assert property (@(posedge CLK) disable iff (RST)
    exp_due |-> (data_out == exp_prod))
    else begin
      fail_count++;
      $error("data_out %0h at %0t, expected %0h", data_out, $time, exp_prod);
    end

  // Ready only with the last element of the run
  ready_last: assert property (@(posedge CLK) disable iff (RST)
    ready == exp_last)
    else begin
      fail_count++;
      $error("ready at %0t does not match the element count", $time);
    end

  reset_quiet: assert property (@(posedge CLK)
    RST |-> (!ready && !data_out_enable && (data_out == '0)))
    else begin
      fail_count++;
      $error("outputs not cleared during reset at %0t", $time);
    end

  release_quiet: assert property (@(posedge CLK)
    $fell(RST) |-> (!ready && !data_out_enable && (data_out == '0)))
    else begin
      fail_count++;
      $error("outputs not cleared after reset release at %0t", $time);
    end

  // Stored config follows only the writes made while idle
  cfg_locked: assert property (@(posedge CLK) disable iff (RST)
    (dut_cfg.modulo == mod_m) && (dut_cfg.length == len_m) && (dut_cfg.valid == cfg_ok))
    else begin
      fail_count++;
      $error("config registers differ from the accepted writes at %0t", $time);
    end

endmodule

bind ntm_vector_top ntm_vector_properties props (
  .CLK              (CLK),
  .RST              (RST),
  .cfg_write        (cfg_write),
  .cfg_addr         (cfg_addr),
  .cfg_wdata        (cfg_wdata),
  .start            (start),
  .ready            (ready),
  .data_a_in        (data_a_in),
  .data_a_in_enable (data_a_in_enable),
  .data_b_in        (data_b_in),
  .data_b_in_enable (data_b_in_enable),
  .data_out         (data_out),
  .data_out_enable  (data_out_enable),
  .dut_cfg          (cfg)
);

// ==== test/ntm_vector_tb.sv ====
// Vector engine testbench
`include "ntm_consts.svh"

module ntm_vector_tb
  import ntm_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RUNS    = 12;
  localparam int MAX_LEN     = 6;
  localparam int DRIVE_DELAY = 2;
  // Per element at most 4 strobe cycles plus the result delay
  localparam int TIMEOUT_CYCLES =
    (NUM_RUNS + 5) * (MAX_LEN * (`NTM_SCALAR_LATENCY + 8) + 20) + 200;

  logic                      CLK;
  logic                      RST;
  logic                      cfg_write;
  ntm_cfg_reg_e              cfg_addr;
  logic [`NTM_DATA_SIZE-1:0] cfg_wdata;
  logic                      start;
  logic                      ready;
  logic [`NTM_DATA_SIZE-1:0] data_a_in;
  logic                      data_a_in_enable;
  logic [`NTM_DATA_SIZE-1:0] data_b_in;
  logic                      data_b_in_enable;
  logic [`NTM_DATA_SIZE-1:0] data_out;
  logic                      data_out_enable;

  logic [31:0]               rng_state;
  logic [`NTM_DATA_SIZE-1:0] cur_mod;
  int                        cur_len;
  int                        cycle_count = 0;

  ntm_clock_gen clock_gen (.CLK(CLK), .RST(RST));

  ntm_vector_top uut (
    .CLK              (CLK),
    .RST              (RST),
    .cfg_write        (cfg_write),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .start            (start),
    .ready            (ready),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // LCG step, value below range
  function automatic int unsigned draw(input int unsigned range);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 8) % range;
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #(DRIVE_DELAY);
  endtask

  task automatic write_config(input ntm_cfg_reg_e addr, input logic [`NTM_DATA_SIZE-1:0] value);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = value;
    next_cycle();
    cfg_write = 1'b0;
  endtask

  // Only used while idle, so both writes land
  task automatic set_config(input logic [`NTM_DATA_SIZE-1:0] modulus, input int len);
    write_config(CFG_MODULO, modulus);
    write_config(CFG_LENGTH, `NTM_DATA_SIZE'(len));
    cur_mod = modulus;
    cur_len = len;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  // A first, B first or both together, with a random gap
  task automatic send_pair(input logic [`NTM_DATA_SIZE-1:0] a,
                           input logic [`NTM_DATA_SIZE-1:0] b);
    int unsigned order;
    int unsigned gap;
    order     = draw(3);
    gap       = draw(4);
    data_a_in = a;
    data_b_in = b;
    if (order == 2) begin
      data_a_in_enable = 1'b1;
      data_b_in_enable = 1'b1;
      next_cycle();
    end else begin
      data_a_in_enable = (order == 0);
      data_b_in_enable = (order == 1);
      next_cycle();
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b0;
      repeat (gap) next_cycle();
      data_a_in_enable = (order == 1);
      data_b_in_enable = (order == 0);
      next_cycle();
    end
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // Poll until the result strobe shows up
  task automatic wait_for_result();
    while (!data_out_enable) next_cycle();
  endtask

  task automatic run_vector(input logic busy_write);
    logic [`NTM_DATA_SIZE-1:0] a;
    logic [`NTM_DATA_SIZE-1:0] b;
    int                        i;
    pulse_start();
    for (i = 0; i < cur_len; i++) begin
      a = `NTM_DATA_SIZE'(draw(32'(cur_mod)));
      b = `NTM_DATA_SIZE'(draw(32'(cur_mod)));
      send_pair(a, b);
      // Writes during the run must be dropped
      if (busy_write && (i == 0)) begin
        write_config(CFG_MODULO, `NTM_DATA_SIZE'(draw(65536)));
        write_config(CFG_LENGTH, `NTM_DATA_SIZE'(draw(256)));
      end
      wait_for_result();
    end
  endtask

  // Start with a bad config, then give it time to misbehave
  task automatic check_ignored_start();
    pulse_start();
    send_pair(`NTM_DATA_SIZE'(1), `NTM_DATA_SIZE'(1));
    repeat (`NTM_SCALAR_LATENCY + 4) next_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Failure and timeout watch
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (uut.props.fail_count != 0) begin
      $display("FAILED at time %0t: a bound check on the DUT did not hold", $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped at the first failing check");
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    cfg_write        = 1'b0;
    cfg_addr         = CFG_MODULO;
    cfg_wdata        = '0;
    start            = 1'b0;
    data_a_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in        = '0;
    data_b_in_enable = 1'b0;
    rng_state        = 32'hbe9a;
    cur_mod          = '0;
    cur_len          = 0;

    @(negedge RST);
    next_cycle();

    // Widest modulus and operands near it
    set_config(16'hffff, 2);
    pulse_start();
    send_pair(16'hfffe, 16'hfffe);
    wait_for_result();
    send_pair(16'h8001, 16'h0003);
    wait_for_result();

    // Modulus 0 or 1, or length 0
    set_config(16'd1, 4);
    check_ignored_start();
    set_config(16'd0, 4);
    check_ignored_start();
    set_config(16'd97, 0);
    check_ignored_start();

    // Every third run keeps the config of a run that saw blocked writes
    for (int run = 0; run < NUM_RUNS; run++) begin
      if ((run % 3) != 2) begin
        set_config(`NTM_DATA_SIZE'(2 + draw(65534)), 1 + int'(draw(MAX_LEN)));
      end
      run_vector((run % 3) == 1);
    end

    repeat (4) next_cycle();
    if (uut.props.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("FAILED at time %0t: %0d bound checks failed", $time, uut.props.fail_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run ended with failing checks");
    end
  end

endmodule

// ==== tb.f ====
+incdir+src
src/ntm_pkg.sv
src/ntm_vector_config.sv
src/ntm_scalar_multiplier.sv
src/ntm_vector_multiplier.sv
src/ntm_vector_top.sv
test/ntm_clock_gen.sv
test/ntm_vector_properties.sv
test/ntm_vector_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f tb.f --top-module ntm_vector_tb -o ntm_vector_sim > build.log 2>&1 \
  && ./obj_dir/ntm_vector_sim +verilator+error+limit+100 2>&1 | tee sim.log

grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
